// ==== design/id_pkg.sv ====
`default_nettype none

package id_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // Fetch starts here out of reset
    localparam word_t reset_pc = 32'h1c00_0000;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or,  alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [3:0] {
        mem_none,
        mem_ld_b, mem_ld_h, mem_ld_w, mem_ld_bu, mem_ld_hu,
        mem_st_b, mem_st_h, mem_st_w
    } mem_op_e;

    typedef enum logic [3:0] {
        br_none,
        br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu,
        br_jirl, br_b, br_bl
    } br_op_e;

    // Everything EX and later need from decode
    typedef struct packed {
        alu_op_e   alu_op;
        mem_op_e   mem_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      res_from_mem;
        logic      gr_we;
        logic      mem_we;
        reg_addr_t dest;
        word_t     imm;
    } dec_ctrl_t;

endpackage

`default_nettype wire

// ==== design/fwd_if.sv ====
`default_nettype none

// Register-write report of one later pipeline stage
interface fwd_if
    import id_pkg::*;
();

    logic      valid;
    logic      gr_we;
    logic      res_from_mem;
    reg_addr_t dest;
    word_t     result;

    modport src (output valid, gr_we, res_from_mem, dest, result);
    modport bypass (input valid, gr_we, res_from_mem, dest, result);

endinterface

`default_nettype wire

// ==== design/inst_decoder.sv ====
`default_nettype none

module inst_decoder
    import id_pkg::*;
(
    input  word_t     inst,
    output dec_ctrl_t ctrl,
    output br_op_e    br_op,
    output reg_addr_t rf_raddr1,
    output reg_addr_t rf_raddr2,
    output word_t     br_offs
);

    reg_addr_t rd;
    reg_addr_t rj;
    reg_addr_t rk;
    alu_op_e   alu_op;
    mem_op_e   mem_op;
    word_t     imm;
    logic      alu_known;
    logic      alu_rr;
    logic      inst_pcaddu12i;
    logic      is_load;
    logic      is_store;
    logic      is_cond_br;
    logic      link;
    logic      need_si20;
    logic      need_ui12;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    // --------------------------------------------------
    // Opcode matching
    // --------------------------------------------------
    always_comb begin
        alu_op    = alu_add;
        alu_known = 1'b1;
        casez (inst[31:15])
            17'h00020:              alu_op = alu_add;
            17'h00022:              alu_op = alu_sub;
            17'h00024:              alu_op = alu_slt;
            17'h00025:              alu_op = alu_sltu;
            17'h00028:              alu_op = alu_nor;
            17'h00029:              alu_op = alu_and;
            17'h0002a:              alu_op = alu_or;
            17'h0002b:              alu_op = alu_xor;
            17'h0002e:              alu_op = alu_sll;
            17'h0002f:              alu_op = alu_srl;
            17'h00030:              alu_op = alu_sra;
            17'h00081:              alu_op = alu_sll;  // Shifts by ui5
            17'h00089:              alu_op = alu_srl;
            17'h00091:              alu_op = alu_sra;
            17'b0000001000_???????: alu_op = alu_slt;
            17'b0000001001_???????: alu_op = alu_sltu;
            17'b0000001010_???????: alu_op = alu_add;
            17'b0000001101_???????: alu_op = alu_and;
            17'b0000001110_???????: alu_op = alu_or;
            17'b0000001111_???????: alu_op = alu_xor;
            17'b0001010_??????????: alu_op = alu_lui;  // lu12i.w
            default:                alu_known = 1'b0;
        endcase
    end

    always_comb begin
        case (inst[31:22])
            10'h0a0: mem_op = mem_ld_b;
            10'h0a1: mem_op = mem_ld_h;
            10'h0a2: mem_op = mem_ld_w;
            10'h0a4: mem_op = mem_st_b;
            10'h0a5: mem_op = mem_st_h;
            10'h0a6: mem_op = mem_st_w;
            10'h0a8: mem_op = mem_ld_bu;
            10'h0a9: mem_op = mem_ld_hu;
            default: mem_op = mem_none;
        endcase
    end

    always_comb begin
        case (inst[31:26])
            6'h13:   br_op = br_jirl;
            6'h14:   br_op = br_b;
            6'h15:   br_op = br_bl;
            6'h16:   br_op = br_beq;
            6'h17:   br_op = br_bne;
            6'h18:   br_op = br_blt;
            6'h19:   br_op = br_bge;
            6'h1a:   br_op = br_bltu;
            6'h1b:   br_op = br_bgeu;
            default: br_op = br_none;
        endcase
    end

    assign inst_pcaddu12i = (inst[31:25] == 7'b0001110);
    assign alu_rr         = alu_known && (inst[31:22] == 10'h000);
    assign is_load        = mem_op inside {mem_ld_b, mem_ld_h, mem_ld_w, mem_ld_bu, mem_ld_hu};
    assign is_store       = mem_op inside {mem_st_b, mem_st_h, mem_st_w};
    assign is_cond_br     = br_op inside {br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};
    assign link           = (br_op == br_jirl) || (br_op == br_bl);
    assign need_si20      = (alu_op == alu_lui) || inst_pcaddu12i;
    assign need_ui12      = alu_known && (inst[31:24] == 8'h03);  // andi, ori, xori

    // --------------------------------------------------
    // Immediates and register numbers
    // --------------------------------------------------
    always_comb begin
        if (link) begin
            imm = 32'd4;  // Return address is pc + 4
        end else if (need_si20) begin
            imm = {inst[24:5], 12'b0};
        end else if (need_ui12) begin
            imm = {20'b0, inst[21:10]};
        end else begin
            imm = {{20{inst[21]}}, inst[21:10]};
        end
    end

    assign br_offs = (br_op == br_b || br_op == br_bl) ?
                     {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0} :
                     {{14{inst[25]}}, inst[25:10], 2'b0};

    assign rf_raddr1 = rj;
    assign rf_raddr2 = (is_cond_br || is_store) ? rd : rk;

    assign ctrl.alu_op       = alu_op;  // Loads, stores and links add
    assign ctrl.mem_op       = mem_op;
    assign ctrl.src1_is_pc   = link || inst_pcaddu12i;
    assign ctrl.src2_is_imm  = (alu_known && !alu_rr) || is_load || is_store ||
                               link || inst_pcaddu12i;
    assign ctrl.res_from_mem = is_load;
    assign ctrl.gr_we        = alu_known || is_load || link || inst_pcaddu12i;
    assign ctrl.mem_we       = is_store;
    assign ctrl.dest         = (br_op == br_bl) ? 5'd1 : rd;
    assign ctrl.imm          = imm;

endmodule

`default_nettype wire

// ==== design/operand_bypass.sv ====
`default_nettype none

module operand_bypass
    import id_pkg::*;
(
    input  reg_addr_t     rf_raddr1,
    input  reg_addr_t     rf_raddr2,
    input  word_t         rf_rdata1,
    input  word_t         rf_rdata2,
    input  logic          src1_is_pc,
    input  logic          src2_is_imm,
    fwd_if.bypass         ex,
    fwd_if.bypass         mem,
    fwd_if.bypass         wb,
    input  logic          in_valid,
    output word_t         rj_value,
    output word_t         rkd_value,
    output logic          load_use_stall
);

    function automatic logic hits(input logic valid, input logic we,
                                  input reg_addr_t dest, input reg_addr_t addr);
        return valid && we && (dest != '0) && (dest == addr);
    endfunction

    // Youngest result wins, loads only forward from WB
    function automatic word_t bypass_value(input reg_addr_t addr, input word_t rf_data);
        if (hits(ex.valid, ex.gr_we && !ex.res_from_mem, ex.dest, addr)) begin
            return ex.result;
        end else if (hits(mem.valid, mem.gr_we && !mem.res_from_mem, mem.dest, addr)) begin
            return mem.result;
        end else if (hits(wb.valid, wb.gr_we, wb.dest, addr)) begin
            return wb.result;
        end
        return rf_data;
    endfunction

    // A load result that is still in flight and read by this instruction
    function automatic logic load_pending(input logic valid, input logic we,
                                          input logic from_mem, input reg_addr_t dest);
        logic use1;
        logic use2;
        use1 = !src1_is_pc && hits(valid, we && from_mem, dest, rf_raddr1);
        use2 = !src2_is_imm && hits(valid, we && from_mem, dest, rf_raddr2);
        return use1 || use2;
    endfunction

    always_comb begin
        rj_value  = bypass_value(rf_raddr1, rf_rdata1);
        rkd_value = bypass_value(rf_raddr2, rf_rdata2);
    end

    always_comb begin
        load_use_stall = in_valid &&
                         (load_pending(ex.valid, ex.gr_we, ex.res_from_mem, ex.dest) ||
                          load_pending(mem.valid, mem.gr_we, mem.res_from_mem, mem.dest));
    end

endmodule

`default_nettype wire

// ==== design/branch_unit.sv ====
`default_nettype none

module branch_unit
    import id_pkg::*;
(
    input  br_op_e br_op,
    input  word_t  pc,
    input  word_t  rj_value,
    input  word_t  rkd_value,
    input  word_t  br_offs,
    output logic   br_hit,
    output word_t  br_target
);

    logic rj_eq_rkd;
    logic rj_lt_rkd;
    logic rj_ltu_rkd;

    assign rj_eq_rkd  = (rj_value == rkd_value);
    assign rj_lt_rkd  = ($signed(rj_value) < $signed(rkd_value));
    assign rj_ltu_rkd = (rj_value < rkd_value);

    always_comb begin
        case (br_op)
            br_beq:               br_hit = rj_eq_rkd;
            br_bne:               br_hit = !rj_eq_rkd;
            br_blt:               br_hit = rj_lt_rkd;
            br_bge:               br_hit = !rj_lt_rkd;
            br_bltu:              br_hit = rj_ltu_rkd;
            br_bgeu:              br_hit = !rj_ltu_rkd;
            br_jirl, br_b, br_bl: br_hit = 1'b1;
            default:              br_hit = 1'b0;
        endcase
    end

    // Only jirl is register relative
    assign br_target = (br_op == br_jirl) ? rj_value + br_offs : pc + br_offs;

endmodule

`default_nettype wire

// ==== design/id_ex_reg.sv ====
`default_nettype none

module id_ex_reg
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  logic      out_ready,
    input  logic      stall,
    input  dec_ctrl_t ctrl,
    input  word_t     pc,
    input  word_t     rj_value,
    input  word_t     rkd_value,
    input  logic      br_hit,
    output logic      in_ready,
    output logic      br_taken,
    fwd_if.src        ex,
    output logic      out_valid,
    output dec_ctrl_t ctrl_out,
    output word_t     pc_out,
    output word_t     rj_value_out,
    output word_t     rkd_value_out
);

    logic accept;

    // --------------------------------------------------
    // Handshake
    // --------------------------------------------------
    assign in_ready = !rst && (!in_valid || (!stall && out_ready));
    assign accept   = in_valid && in_ready;
    assign br_taken = accept && br_hit;  // Redirect fetch once per branch

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= accept;
        end
    end

    // --------------------------------------------------
    // Pipeline register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_out <= '0;
            pc_out   <= reset_pc;
        end else if (accept) begin
            ctrl_out <= ctrl;
            pc_out   <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rj_value_out  <= rj_value;
            rkd_value_out <= rkd_value;
        end
    end

    // The held instruction is what EX is working on
    assign ex.valid        = out_valid;
    assign ex.gr_we        = ctrl_out.gr_we;
    assign ex.res_from_mem = ctrl_out.res_from_mem;
    assign ex.dest         = ctrl_out.dest;

endmodule

`default_nettype wire

// ==== design/id_stage.sv ====
`default_nettype none

module id_stage
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  word_t     inst,
    input  word_t     pc,
    output logic      in_ready,
    input  logic      out_ready,
    output logic      out_valid,
    output reg_addr_t rf_raddr1,
    output reg_addr_t rf_raddr2,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    input  word_t     ex_result,
    input  logic      mem_valid,
    input  logic      mem_gr_we,
    input  logic      mem_res_from_mem,
    input  reg_addr_t mem_dest,
    input  word_t     mem_result,
    input  logic      wb_valid,
    input  logic      wb_gr_we,
    input  reg_addr_t wb_dest,
    input  word_t     wb_result,
    output logic      br_taken,
    output word_t     br_target,
    output alu_op_e   alu_op_out,
    output mem_op_e   mem_op_out,
    output logic      src1_is_pc_out,
    output logic      src2_is_imm_out,
    output logic      res_from_mem_out,
    output logic      gr_we_out,
    output logic      mem_we_out,
    output reg_addr_t dest_out,
    output word_t     imm_out,
    output word_t     pc_out,
    output word_t     rj_value_out,
    output word_t     rkd_value_out
);

    dec_ctrl_t ctrl;
    dec_ctrl_t ctrl_out;
    br_op_e    br_op;
    word_t     br_offs;
    word_t     rj_value;
    word_t     rkd_value;
    logic      load_use_stall;
    logic      br_hit;

    fwd_if ex_fwd ();
    fwd_if mem_fwd ();
    fwd_if wb_fwd ();

    assign ex_fwd.result = ex_result;

    assign mem_fwd.valid        = mem_valid;
    assign mem_fwd.gr_we        = mem_gr_we;
    assign mem_fwd.res_from_mem = mem_res_from_mem;
    assign mem_fwd.dest         = mem_dest;
    assign mem_fwd.result       = mem_result;

    assign wb_fwd.valid        = wb_valid;
    assign wb_fwd.gr_we        = wb_gr_we;
    assign wb_fwd.res_from_mem = 1'b0;  // Load data is final by WB
    assign wb_fwd.dest         = wb_dest;
    assign wb_fwd.result       = wb_result;

    inst_decoder u_inst_decoder (
        .inst      (inst),
        .ctrl      (ctrl),
        .br_op     (br_op),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .br_offs   (br_offs)
    );

    operand_bypass u_operand_bypass (
        .rf_raddr1      (rf_raddr1),
        .rf_raddr2      (rf_raddr2),
        .rf_rdata1      (rf_rdata1),
        .rf_rdata2      (rf_rdata2),
        .src1_is_pc     (ctrl.src1_is_pc),
        .src2_is_imm    (ctrl.src2_is_imm),
        .ex             (ex_fwd.bypass),
        .mem            (mem_fwd.bypass),
        .wb             (wb_fwd.bypass),
        .in_valid       (in_valid),
        .rj_value       (rj_value),
        .rkd_value      (rkd_value),
        .load_use_stall (load_use_stall)
    );

    branch_unit u_branch_unit (
        .br_op     (br_op),
        .pc        (pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_offs   (br_offs),
        .br_hit    (br_hit),
        .br_target (br_target)
    );

    id_ex_reg u_id_ex_reg (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .out_ready     (out_ready),
        .stall         (load_use_stall),
        .ctrl          (ctrl),
        .pc            (pc),
        .rj_value      (rj_value),
        .rkd_value     (rkd_value),
        .br_hit        (br_hit),
        .in_ready      (in_ready),
        .br_taken      (br_taken),
        .ex            (ex_fwd.src),
        .out_valid     (out_valid),
        .ctrl_out      (ctrl_out),
        .pc_out        (pc_out),
        .rj_value_out  (rj_value_out),
        .rkd_value_out (rkd_value_out)
    );

    assign alu_op_out       = ctrl_out.alu_op;
    assign mem_op_out       = ctrl_out.mem_op;
    assign src1_is_pc_out   = ctrl_out.src1_is_pc;
    assign src2_is_imm_out  = ctrl_out.src2_is_imm;
    assign res_from_mem_out = ctrl_out.res_from_mem;
    assign gr_we_out        = ctrl_out.gr_we;
    assign mem_we_out       = ctrl_out.mem_we;
    assign dest_out         = ctrl_out.dest;
    assign imm_out          = ctrl_out.imm;

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = !clk;  // Period of 20
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== sim/id_stage_props.sv ====
`default_nettype none

module id_stage_props
    import id_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      in_valid,
    input word_t     pc,
    input logic      in_ready,
    input logic      out_ready,
    input logic      out_valid,
    input logic      br_taken,
    input alu_op_e   alu_op_out,
    input mem_op_e   mem_op_out,
    input logic      src1_is_pc_out,
    input logic      src2_is_imm_out,
    input logic      res_from_mem_out,
    input logic      gr_we_out,
    input logic      mem_we_out,
    input reg_addr_t dest_out,
    input word_t     imm_out,
    input word_t     pc_out,
    input word_t     rj_value_out,
    input word_t     rkd_value_out
);

    // Nothing leaves the stage in the first cycle out of reset
    assert property (@(posedge clk) $fell(rst) |-> !out_valid)
        else $error("out_valid high in the first cycle after reset");

    // A taken branch is accepted and lands in ID/EX on the next edge
    assert property (@(posedge clk) disable iff (rst)
        br_taken |-> in_valid && in_ready ##1 out_valid && pc_out == $past(pc))
        else $error("br_taken without the branch being captured in ID/EX");

    assert property (@(posedge clk) disable iff (rst)
        !out_ready |=> $stable(out_valid) && $stable(alu_op_out) && $stable(mem_op_out) &&
                       $stable(src1_is_pc_out) && $stable(src2_is_imm_out) &&
                       $stable(res_from_mem_out) && $stable(gr_we_out) &&
                       $stable(mem_we_out) && $stable(dest_out) &&
                       $stable(imm_out) && $stable(pc_out) && $stable(rj_value_out) &&
                       $stable(rkd_value_out))
        else $error("ID/EX register changed while out_ready was low");

endmodule

bind id_stage id_stage_props u_id_stage_props (.*);

`default_nettype wire

// ==== sim/id_stage_tb.sv ====
`default_nettype none

module id_stage_tb
    import id_pkg::*;
();

    localparam int timeout_cycles = 2000;

    logic      clk;
    logic      rst;
    logic      in_valid;
    word_t     inst;
    word_t     pc;
    logic      in_ready;
    logic      out_ready;
    logic      out_valid;
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     ex_result;
    logic      mem_valid;
    logic      mem_gr_we;
    logic      mem_res_from_mem;
    reg_addr_t mem_dest;
    word_t     mem_result;
    logic      wb_valid;
    logic      wb_gr_we;
    reg_addr_t wb_dest;
    word_t     wb_result;
    logic      br_taken;
    word_t     br_target;
    alu_op_e   alu_op_out;
    mem_op_e   mem_op_out;
    logic      src1_is_pc_out;
    logic      src2_is_imm_out;
    logic      res_from_mem_out;
    logic      gr_we_out;
    logic      mem_we_out;
    reg_addr_t dest_out;
    word_t     imm_out;
    word_t     pc_out;
    word_t     rj_value_out;
    word_t     rkd_value_out;

    word_t rf [32];
    word_t lfsr_state;
    int    cycles;

    tb_clock u_tb_clock (.clk(clk), .rst(rst));

    id_stage u_id_stage (.*);

    // Register file model with r0 hardwired to zero
    assign rf_rdata1 = (rf_raddr1 == '0) ? '0 : rf[rf_raddr1];
    assign rf_rdata2 = (rf_raddr2 == '0) ? '0 : rf[rf_raddr2];

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout after %0d cycles without finishing the tests", cycles);
            $display("tests failed");
            $fatal(1);
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic word_t rf_val(input reg_addr_t r);
        return (r == '0) ? '0 : rf[r];
    endfunction

    function automatic word_t enc_3r(input logic [16:0] op, input reg_addr_t rk,
                                     input reg_addr_t rj, input reg_addr_t rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic word_t enc_2ri12(input logic [9:0] op, input logic [11:0] imm,
                                        input reg_addr_t rj, input reg_addr_t rd);
        return {op, imm, rj, rd};
    endfunction

    function automatic word_t enc_2ri16(input logic [5:0] op, input logic [15:0] offs,
                                        input reg_addr_t rj, input reg_addr_t rd);
        return {op, offs, rj, rd};
    endfunction

    function automatic word_t enc_i26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // Presents one instruction and returns just after the edge that takes it
    task automatic send(input word_t instr, input word_t at_pc);
        inst     = instr;
        pc       = at_pc;
        in_valid = 1'b1;
        #1;
        while (!in_ready) step();
        step();
        in_valid = 1'b0;
    endtask

    task automatic set_operands(input word_t x, input word_t y);
        mem_valid        = 1'b1;  // MEM carries r20 and WB carries r21
        mem_gr_we        = 1'b1;
        mem_res_from_mem = 1'b0;
        mem_dest         = 5'd20;
        mem_result       = x;
        wb_valid         = 1'b1;
        wb_gr_we         = 1'b1;
        wb_dest          = 5'd21;
        wb_result        = y;
    endtask

    task automatic clear_reports();
        mem_valid = 1'b0;
        wb_valid  = 1'b0;
    endtask

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_word(input string name, input word_t act, input word_t exp);
        if (act !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, act, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t act, input reg_addr_t exp);
        if (act !== exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, act, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_alu(input string name, input alu_op_e act, input alu_op_e exp);
        if (act !== exp) begin
            $display("Fail at %0t: %s is %s, expected %s", $time, name, act.name(), exp.name());
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_mem(input string name, input mem_op_e act, input mem_op_e exp);
        if (act !== exp) begin
            $display("Fail at %0t: %s is %s, expected %s", $time, name, act.name(), exp.name());
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, act, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_bundle(input alu_op_e alu, input mem_op_e mop, input logic we,
                                input logic mwe, input reg_addr_t dest, input word_t imm,
                                input word_t at_pc, input word_t rj);
        check_bit("out_valid", out_valid, 1'b1);
        check_alu("alu_op_out", alu_op_out, alu);
        check_mem("mem_op_out", mem_op_out, mop);
        check_bit("gr_we_out", gr_we_out, we);
        check_bit("mem_we_out", mem_we_out, mwe);
        check_bit("res_from_mem_out", res_from_mem_out, mop inside {mem_ld_w});
        check_addr("dest_out", dest_out, dest);
        check_word("imm_out", imm_out, imm);
        check_word("pc_out", pc_out, at_pc);
        check_word("rj_value_out", rj_value_out, rj);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset();
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("br_taken", br_taken, 1'b0);
        check_bit("gr_we_out", gr_we_out, 1'b0);
        check_word("pc_out", pc_out, reset_pc);
        check_bit("in_ready", in_ready, 1'b1);
    endtask

    task automatic test_decode();
        send(enc_3r(17'h00020, 5'd4, 5'd3, 5'd5), 32'h1c00_0100);  // add.w
        check_bundle(alu_add, mem_none, 1, 0, 5'd5, 32'h0000_0404, 32'h1c00_0100, rf_val(3));
        check_bit("src1_is_pc_out", src1_is_pc_out, 1'b0);
        check_bit("src2_is_imm_out", src2_is_imm_out, 1'b0);
        check_word("rkd_value_out", rkd_value_out, rf_val(4));
        step();
        send(enc_2ri12(10'h00a, 12'hffd, 5'd7, 5'd6), 32'h1c00_0104);  // addi.w -3
        check_bundle(alu_add, mem_none, 1, 0, 5'd6, 32'hffff_fffd, 32'h1c00_0104, rf_val(7));
        check_bit("src2_is_imm_out", src2_is_imm_out, 1'b1);
        step();
        send(enc_2ri12(10'h00e, 12'hf0f, 5'd9, 5'd8), 32'h1c00_0108);  // ori
        check_bundle(alu_or, mem_none, 1, 0, 5'd8, 32'h0000_0f0f, 32'h1c00_0108, rf_val(9));
        step();
        send({7'b0001010, 20'h80001, 5'd10}, 32'h1c00_010c);  // lu12i.w
        check_bundle(alu_lui, mem_none, 1, 0, 5'd10, 32'h8000_1000, 32'h1c00_010c,
                     rf_val(5'd1));
        step();
        send(enc_2ri12(10'h0a2, 12'h7fc, 5'd12, 5'd11), 32'h1c00_0110);  // ld.w
        check_bundle(alu_add, mem_ld_w, 1, 0, 5'd11, 32'h0000_07fc, 32'h1c00_0110, rf_val(12));
        step();
        send(enc_2ri12(10'h0a6, 12'hff8, 5'd14, 5'd13), 32'h1c00_0114);  // st.w -8
        check_bundle(alu_add, mem_st_w, 0, 1, 5'd13, 32'hffff_fff8, 32'h1c00_0114, rf_val(14));
        check_word("rkd_value_out", rkd_value_out, rf_val(13));
        step();
    endtask

    task automatic test_forwarding();
        set_operands(32'h0, 32'h0);
        mem_dest   = 5'd3;
        mem_result = 32'haaaa_0001;
        wb_dest    = 5'd3;
        wb_result  = 32'hbbbb_0002;
        send(enc_3r(17'h00020, 5'd4, 5'd3, 5'd5), 32'h1c00_0200);
        check_word("rj_value_out", rj_value_out, 32'haaaa_0001);
        check_word("rkd_value_out", rkd_value_out, rf_val(4));
        step();
        mem_valid = 1'b0;
        wb_dest   = 5'd4;
        send(enc_3r(17'h00020, 5'd4, 5'd3, 5'd5), 32'h1c00_0204);
        check_word("rkd_value_out", rkd_value_out, 32'hbbbb_0002);
        step();
        mem_valid = 1'b1;  // r0 reports are ignored
        mem_dest  = 5'd0;
        wb_dest   = 5'd0;
        send(enc_3r(17'h00020, 5'd0, 5'd0, 5'd5), 32'h1c00_0208);
        check_word("rj_value_out", rj_value_out, 32'h0);
        check_word("rkd_value_out", rkd_value_out, 32'h0);
        step();
        clear_reports();
        send(enc_3r(17'h00020, 5'd4, 5'd3, 5'd5), 32'h1c00_020c);
        ex_result = 32'h1234_5678;
        send(enc_3r(17'h00020, 5'd4, 5'd5, 5'd6), 32'h1c00_0210);  // Reads r5 from EX
        check_word("rj_value_out", rj_value_out, 32'h1234_5678);
        step();
    endtask

    task automatic test_load_use();
        send(enc_2ri12(10'h0a2, 12'h000, 5'd12, 5'd11), 32'h1c00_0300);
        inst     = enc_3r(17'h00020, 5'd4, 5'd11, 5'd5);
        pc       = 32'h1c00_0304;
        in_valid = 1'b1;
        #1;
        check_bit("in_ready", in_ready, 1'b0);
        step();
        check_bit("out_valid", out_valid, 1'b0);
        mem_valid        = 1'b1;  // The load moves on to MEM
        mem_gr_we        = 1'b1;
        mem_res_from_mem = 1'b1;
        mem_dest         = 5'd11;
        #1;
        check_bit("in_ready", in_ready, 1'b0);
        step();
        check_bit("out_valid", out_valid, 1'b0);
        mem_valid = 1'b0;
        wb_valid  = 1'b1;
        wb_gr_we  = 1'b1;
        wb_dest   = 5'd11;
        wb_result = 32'hdead_0011;
        #1;
        check_bit("in_ready", in_ready, 1'b1);
        step();
        in_valid = 1'b0;
        check_bit("out_valid", out_valid, 1'b1);
        check_word("pc_out", pc_out, 32'h1c00_0304);
        check_word("rj_value_out", rj_value_out, 32'hdead_0011);
        clear_reports();
        mem_res_from_mem = 1'b0;
        step();
    endtask

    task automatic check_branch(input string what, input word_t instr, input word_t at_pc,
                                input logic exp_taken, input word_t exp_target);
        inst     = instr;
        pc       = at_pc;
        in_valid = 1'b1;
        #1;
        while (!in_ready) step();
        check_bit({what, " br_taken"}, br_taken, exp_taken);
        if (exp_taken) begin
            check_word({what, " br_target"}, br_target, exp_target);
        end
        step();
        in_valid = 1'b0;
        step();
    endtask

    task automatic test_branches();
        word_t p;
        p = 32'h1c00_0400;
        set_operands(32'd5, 32'd5);
        check_branch("beq", enc_2ri16(6'h16, 16'h0010, 5'd20, 5'd21), p, 1, p + 32'h40);
        check_branch("bne", enc_2ri16(6'h17, 16'h0010, 5'd20, 5'd21), p, 0, 32'h0);
        set_operands(32'd5, 32'd6);
        check_branch("beq", enc_2ri16(6'h16, 16'hfffc, 5'd20, 5'd21), p, 0, 32'h0);
        check_branch("bne", enc_2ri16(6'h17, 16'hfffc, 5'd20, 5'd21), p, 1, p - 32'd16);
        set_operands(32'hffff_ffff, 32'd1);  // -1 against 1
        check_branch("blt", enc_2ri16(6'h18, 16'h0008, 5'd20, 5'd21), p, 1, p + 32'h20);
        check_branch("bltu", enc_2ri16(6'h1a, 16'h0008, 5'd20, 5'd21), p, 0, 32'h0);
        set_operands(32'd1, 32'hffff_ffff);
        check_branch("blt", enc_2ri16(6'h18, 16'h0008, 5'd20, 5'd21), p, 0, 32'h0);
        check_branch("bltu", enc_2ri16(6'h1a, 16'h0008, 5'd20, 5'd21), p, 1, p + 32'h20);
        check_branch("b", enc_i26(6'h14, 26'h3ffff00), p, 1, p - 32'd1024);
        check_branch("bl", enc_i26(6'h15, 26'h0010000), p, 1, p + 32'h0004_0000);
        check_addr("dest_out", dest_out, 5'd1);
        check_bit("gr_we_out", gr_we_out, 1'b1);
        check_bit("src1_is_pc_out", src1_is_pc_out, 1'b1);
        check_word("imm_out", imm_out, 32'd4);
        set_operands(32'h1c00_1000, 32'd0);
        check_branch("jirl", enc_2ri16(6'h13, 16'h0008, 5'd20, 5'd2), p, 1, 32'h1c00_1020);
        check_addr("dest_out", dest_out, 5'd2);
    endtask

    task automatic test_backpressure();
        set_operands(32'd7, 32'd7);
        send(enc_3r(17'h00020, 5'd4, 5'd3, 5'd5), 32'h1c00_0500);
        out_ready = 1'b0;
        inst      = enc_2ri16(6'h16, 16'h0004, 5'd20, 5'd21);  // Taken beq waits
        pc        = 32'h1c00_0504;
        in_valid  = 1'b1;
        #1;
        repeat (3) begin
            check_bit("in_ready", in_ready, 1'b0);
            check_bit("br_taken", br_taken, 1'b0);
            step();
            check_bit("out_valid", out_valid, 1'b1);
            check_word("pc_out", pc_out, 32'h1c00_0500);
            check_addr("dest_out", dest_out, 5'd5);
            check_word("rj_value_out", rj_value_out, rf_val(3));
        end
        out_ready = 1'b1;
        #1;
        check_bit("in_ready", in_ready, 1'b1);
        check_bit("br_taken", br_taken, 1'b1);
        check_word("br_target", br_target, 32'h1c00_0514);
        step();
        in_valid = 1'b0;
        check_bit("out_valid", out_valid, 1'b1);
        check_word("pc_out", pc_out, 32'h1c00_0504);
        clear_reports();
        step();
    endtask

    initial begin
        cycles           = 0;
        in_valid         = 1'b0;
        inst             = '0;
        pc               = '0;
        out_ready        = 1'b1;
        ex_result        = '0;
        mem_valid        = 1'b0;
        mem_gr_we        = 1'b0;
        mem_res_from_mem = 1'b0;
        mem_dest         = '0;
        mem_result       = '0;
        wb_valid         = 1'b0;
        wb_gr_we         = 1'b0;
        wb_dest          = '0;
        wb_result        = '0;
        lfsr_state       = 32'd27;
        for (int r = 0; r < 32; r++) begin
            for (int b = 0; b < 32; b++) begin
                rf[r][b] = lfsr_bit();
            end
        end
        #1;
        while (rst) step();
        test_reset();
        test_decode();
        test_forwarding();
        test_load_use();
        test_branches();
        test_backpressure();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/id_pkg.sv
design/fwd_if.sv
design/inst_decoder.sv
design/operand_bypass.sv
design/branch_unit.sv
design/id_ex_reg.sv
design/id_stage.sv
sim/tb_clock.sv
sim/id_stage_props.sv
sim/id_stage_tb.sv
